//--- logic/mul_pkg.sv
// --------------------
// Widths, operation codes and pipeline structs of the RV32 M multiply path
// Latency constants must stay consistent with the array stage count
// --------------------
`default_nettype none

package mul_pkg;

    // --------------------
    // Widths and latency
    // --------------------

    // One RV32 word
    localparam int XLEN = 32;
    // The full unsigned product of two words
    localparam int RESULT_WIDTH = 2 * XLEN;

    // Register stages inside the array multiplier
    localparam int ARRAY_STAGES = 7;
    // Multiplier bits consumed by each array stage, rounded up
    localparam int MUL_BITS_PER_STAGE = (XLEN + ARRAY_STAGES - 1) / ARRAY_STAGES;
    // Input register, array stages and output register
    localparam int UNIT_LATENCY = ARRAY_STAGES + 2;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [RESULT_WIDTH-1:0] product_t;

    // Encoding follows funct3 bits 1:0 of the M extension multiplies
    typedef enum logic [1:0] {
        MUL    = 2'd0,
        MULH   = 2'd1,
        MULHSU = 2'd2,
        MULHU  = 2'd3
    } mul_operation_t;

    // One operand pair entering the multiply pipeline
    typedef struct packed {
        xlen_t          multiplicand;
        xlen_t          multiplier;
        mul_operation_t operation;
        logic           valid;
    } mul_req_t;

    // Selected result word leaving the pipeline
    typedef struct packed {
        xlen_t product;
        logic  valid;
    } mul_rsp_t;

endpackage : mul_pkg

`default_nettype wire

//--- logic/wb_pkg.sv
// --------------------
// Wishbone classic bus types and register map, full-word accesses only
// --------------------
`default_nettype none

package wb_pkg;

    // --------------------
    // Bus widths
    // --------------------
    localparam int WB_ADR_WIDTH = 5;
    localparam int WB_DAT_WIDTH = 32;

    typedef logic [WB_ADR_WIDTH-1:0] wb_adr_t;
    typedef logic [WB_DAT_WIDTH-1:0] wb_dat_t;

    // Master to slave signals of one classic cycle
    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;
    } wb_req_t;

    // Slave to master signals, dat is valid while ack is high
    typedef struct packed {
        logic    ack;
        wb_dat_t dat;
    } wb_rsp_t;

    // --------------------
    // Register offsets in bytes
    // --------------------
    localparam wb_adr_t REG_OPA    = 5'h00;
    localparam wb_adr_t REG_OPB    = 5'h04;
    localparam wb_adr_t REG_CTRL   = 5'h08;
    localparam wb_adr_t REG_RESULT = 5'h0C;
    localparam wb_adr_t REG_STATUS = 5'h10;

    // Bit positions inside the status register
    localparam int STAT_BUSY = 0;
    localparam int STAT_DONE = 1;

endpackage : wb_pkg

`default_nettype wire

//--- logic/pipelined_array_multiplier.sv
// --------------------
// Unsigned operands only, latency is ARRAY_STAGES cycles
// Accepts a new pair every cycle and never stalls
// --------------------
`timescale 1ns/1ns
`default_nettype none

module pipelined_array_multiplier import mul_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire xlen_t    multiplicand_i,
    input  wire xlen_t    multiplier_i,
    input  wire logic     valid_i,
    output      product_t product_o,
    output      logic     valid_o
);

    // Multiplier padded with zeros so every stage gets a full slice
    localparam int PADDED_WIDTH = MUL_BITS_PER_STAGE * ARRAY_STAGES;

    for (genvar s = 0; s < ARRAY_STAGES; s++) begin : g_stage
        product_t                      sum_in;
        product_t                      sum_next;
        xlen_t                         mcand_in;
        xlen_t                         mplier_in;
        logic                          valid_in;
        logic [PADDED_WIDTH-1:0]       mplier_pad;
        logic [MUL_BITS_PER_STAGE-1:0] slice;
        product_t                      sum_q;
        logic                          valid_q;

        // The first stage starts from an empty sum
        if (s == 0) begin : g_head
            assign sum_in    = '0;
            assign mcand_in  = multiplicand_i;
            assign mplier_in = multiplier_i;
            assign valid_in  = valid_i;
        end else begin : g_link
            assign sum_in    = g_stage[s-1].sum_q;
            assign mcand_in  = g_stage[s-1].g_fwd.mcand_q;
            assign mplier_in = g_stage[s-1].g_fwd.mplier_q;
            assign valid_in  = g_stage[s-1].valid_q;
        end

        assign mplier_pad = PADDED_WIDTH'(mplier_in);
        // Bits of the multiplier handled in this stage
        assign slice = mplier_pad[s*MUL_BITS_PER_STAGE +: MUL_BITS_PER_STAGE];

        // Shift and add of the partial products of this slice
        always_comb begin
            sum_next = sum_in;
            for (int j = 0; j < MUL_BITS_PER_STAGE; j++) begin
                if (slice[j]) begin
                    sum_next = sum_next + (product_t'(mcand_in) << (s * MUL_BITS_PER_STAGE + j));
                end
            end
        end

        always_ff @(posedge clk_i) begin
            sum_q <= sum_next;
        end

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                valid_q <= 1'b0;
            end else begin
                valid_q <= valid_in;
            end
        end

        // Operands ride along until the last stage, which needs them no further
        if (s < ARRAY_STAGES - 1) begin : g_fwd
            xlen_t mcand_q;
            xlen_t mplier_q;

            always_ff @(posedge clk_i) begin
                mcand_q  <= mcand_in;
                mplier_q <= mplier_in;
            end
        end
    end

    assign product_o = g_stage[ARRAY_STAGES-1].sum_q;
    assign valid_o   = g_stage[ARRAY_STAGES-1].valid_q;

endmodule : pipelined_array_multiplier

`default_nettype wire

//--- logic/multiplication_unit.sv
// --------------------
// MUL, MULH, MULHSU and MULHU with a fixed latency of UNIT_LATENCY cycles
// No stall input, a new request may enter every cycle
// --------------------
`timescale 1ns/1ns
`default_nettype none

module multiplication_unit import mul_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire mul_req_t mul_req_i,
    output      mul_rsp_t mul_rsp_o
);

    // --------------------
    // Input stage
    // --------------------

    // Multiplicand is signed for all but MULHU, multiplier only for MUL and MULH
    logic  signed_a;
    logic  signed_b;
    logic  neg_a;
    logic  neg_b;
    logic  negate;
    xlen_t mag_a;
    xlen_t mag_b;

    assign signed_a = (mul_req_i.operation != MULHU);
    assign signed_b = (mul_req_i.operation == MUL) || (mul_req_i.operation == MULH);

    // Effective signs, an unsigned operand is never negative
    assign neg_a = signed_a & mul_req_i.multiplicand[XLEN-1];
    assign neg_b = signed_b & mul_req_i.multiplier[XLEN-1];

    // The product is negative only when exactly one effective sign is set
    assign negate = neg_a ^ neg_b;

    // Magnitudes for the unsigned array, the most negative value maps to 2^31
    always_comb begin
        mag_a = mul_req_i.multiplicand;
        mag_b = mul_req_i.multiplier;
        if (neg_a) begin
            mag_a = ~mul_req_i.multiplicand + 1'b1;
        end
        if (neg_b) begin
            mag_b = ~mul_req_i.multiplier + 1'b1;
        end
    end

    xlen_t mcand_q;
    xlen_t mplier_q;
    logic  in_valid_q;

    always_ff @(posedge clk_i) begin
        mcand_q  <= mag_a;
        mplier_q <= mag_b;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            in_valid_q <= 1'b0;
        end else begin
            in_valid_q <= mul_req_i.valid;
        end
    end

    // Operation and sign fix travel beside the data, tap UNIT_LATENCY-1 meets the output
    mul_operation_t [UNIT_LATENCY-1:0] op_sr;
    logic [UNIT_LATENCY-1:0]           negate_sr;

    always_ff @(posedge clk_i) begin
        op_sr     <= {op_sr[UNIT_LATENCY-2:0], mul_req_i.operation};
        negate_sr <= {negate_sr[UNIT_LATENCY-2:0], negate};
    end

    // --------------------
    // Array and output stage
    // --------------------
    product_t array_product;
    logic     array_valid;

    pipelined_array_multiplier u_array (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .multiplicand_i (mcand_q),
        .multiplier_i   (mplier_q),
        .valid_i        (in_valid_q),
        .product_o      (array_product),
        .valid_o        (array_valid)
    );

    product_t prod_q;
    logic     out_valid_q;
    product_t signed_product;

    always_ff @(posedge clk_i) begin
        prod_q <= array_product;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= array_valid;
        end
    end

    assign signed_product = negate_sr[UNIT_LATENCY-1] ? (~prod_q + 1'b1) : prod_q;

    // MUL keeps the low word, every high variant the upper one
    always_comb begin
        case (op_sr[UNIT_LATENCY-1])
            MUL:     mul_rsp_o.product = signed_product[XLEN-1:0];
            default: mul_rsp_o.product = signed_product[RESULT_WIDTH-1:XLEN];
        endcase
    end

    assign mul_rsp_o.valid = out_valid_q;

    // Each request comes out exactly UNIT_LATENCY cycles later
    a_latency : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mul_rsp_o.valid == $past(mul_req_i.valid, UNIT_LATENCY));

endmodule : multiplication_unit

`default_nettype wire

//--- logic/mul_wb_slave.sv
// --------------------
// Wishbone classic slave, word accesses only, no error or retry
// One operation at a time, a CTRL write while busy is dropped
// --------------------
`timescale 1ns/1ns
`default_nettype none

module mul_wb_slave import mul_pkg::*, wb_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire wb_req_t  wb_req_i,
    output      wb_rsp_t  wb_rsp_o,
    output      mul_req_t mul_req_o,
    input  wire mul_rsp_t mul_rsp_i
);

    logic           req_pending;
    logic           wr_ctrl;
    logic           rd_result;
    logic           ack_q;
    xlen_t          opa_q;
    xlen_t          opb_q;
    xlen_t          result_q;
    mul_operation_t op_q;
    logic           launch_q;
    logic           busy_q;
    logic           done_q;
    wb_dat_t        rdata_next;
    wb_dat_t        rdata_q;

    // A request counts once, the ack cycle itself never starts another access
    assign req_pending = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    assign wr_ctrl     = req_pending & wb_req_i.we & (wb_req_i.adr == REG_CTRL);
    assign rd_result   = req_pending & ~wb_req_i.we & (wb_req_i.adr == REG_RESULT);

    // --------------------
    // Read decode
    // --------------------
    always_comb begin
        rdata_next = '0;
        case (wb_req_i.adr)
            REG_RESULT: rdata_next = result_q;
            REG_STATUS: begin
                rdata_next[STAT_BUSY] = busy_q;
                rdata_next[STAT_DONE] = done_q;
            end
            // Operand and control registers are write only
            default: rdata_next = '0;
        endcase
    end

    // --------------------
    // Register file
    // --------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_q    <= 1'b0;
            opa_q    <= '0;
            opb_q    <= '0;
            result_q <= '0;
            op_q     <= MUL;
            launch_q <= 1'b0;
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            rdata_q  <= '0;
        end else begin
            ack_q    <= req_pending;
            launch_q <= 1'b0;

            if (req_pending) begin
                rdata_q <= wb_req_i.we ? '0 : rdata_next;
            end

            if (req_pending & wb_req_i.we & (wb_req_i.adr == REG_OPA)) begin
                opa_q <= wb_req_i.dat;
            end
            if (req_pending & wb_req_i.we & (wb_req_i.adr == REG_OPB)) begin
                opb_q <= wb_req_i.dat;
            end

            // Launch pulse lines up with the ack of the CTRL write
            if (wr_ctrl & ~busy_q) begin
                op_q     <= mul_operation_t'(wb_req_i.dat[1:0]);
                launch_q <= 1'b1;
                busy_q   <= 1'b1;
                done_q   <= 1'b0;
            end

            if (rd_result) begin
                done_q <= 1'b0;
            end

            // A finishing operation wins over a result read in the same cycle
            if (mul_rsp_i.valid) begin
                result_q <= mul_rsp_i.product;
                busy_q   <= 1'b0;
                done_q   <= 1'b1;
            end
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rdata_q;

    assign mul_req_o.multiplicand = opa_q;
    assign mul_req_o.multiplier   = opb_q;
    assign mul_req_o.operation    = op_q;
    assign mul_req_o.valid        = launch_q;

    a_ack_single : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_rsp_o.ack |=> !wb_rsp_o.ack);

    // The unit only answers what this slave launched
    a_rsp_when_busy : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mul_rsp_i.valid |-> busy_q);

endmodule : mul_wb_slave

`default_nettype wire

//--- logic/mul_subsystem.sv
// --------------------
// Bus-attached multiply unit, result ready UNIT_LATENCY+1 cycles after the CTRL ack
// --------------------
`timescale 1ns/1ns
`default_nettype none

module mul_subsystem import mul_pkg::*, wb_pkg::*; (
    input  wire logic    clk_i,
    input  wire logic    rst_n_i,
    input  wire wb_req_t wb_req_i,
    output      wb_rsp_t wb_rsp_o
);

    // Launch request from the slave and the selected word coming back
    mul_req_t mul_req;
    mul_rsp_t mul_rsp;

    mul_wb_slave u_slave (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wb_req_i  (wb_req_i),
        .wb_rsp_o  (wb_rsp_o),
        .mul_req_o (mul_req),
        .mul_rsp_i (mul_rsp)
    );

    multiplication_unit u_mul (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .mul_req_i (mul_req),
        .mul_rsp_o (mul_rsp)
    );

endmodule : mul_subsystem

`default_nettype wire

//--- bench/tb_mul_subsystem.sv
// --------------------
// Run from the project root so that bench/mul_testdata.hex is found
// --------------------
`timescale 1ns/1ns
`default_nettype none

module tb_mul_subsystem import mul_pkg::*, wb_pkg::*; ();

    localparam int MAX_VECTORS  = 64;
    localparam int ACK_TIMEOUT  = 20;
    localparam int POLL_LIMIT   = 4 * UNIT_LATENCY;
    localparam int RANDOM_TESTS = 24;

    logic        clk;
    logic        rst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic [31:0] vec_mem [0:4*MAX_VECTORS-1];
    integer      seed;
    int          test_count;
    int          failed_tests;
    int          error_count;
    logic        test_failed;

    mul_subsystem dut0 (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------
    // Bus tasks
    // --------------------

    // Starts on a falling edge and returns on the falling edge where ack was seen
    task automatic bus_access(input logic we, input wb_adr_t adr, input xlen_t wdata,
                              output xlen_t rdata);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        rdata  = '0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdata};
        while (!seen && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (wb_rsp.ack) begin
                seen  = 1'b1;
                rdata = wb_rsp.dat;
            end
        end
        // Master drops the cycle in the ack cycle
        wb_req = '0;
        if (!seen) begin
            $display("No Wishbone ack for address 0x%02h within %0d cycles", adr, ACK_TIMEOUT);
            error_count++;
            test_failed = 1'b1;
        end
    endtask

    task automatic write_reg(input wb_adr_t adr, input xlen_t data);
        xlen_t unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic read_reg(input wb_adr_t adr, output xlen_t data);
        bus_access(1'b0, adr, '0, data);
    endtask

    // Busy must hold on every poll until done shows up
    task automatic wait_for_done();
        xlen_t status;
        int    polls;
        logic  finished;
        finished = 1'b0;
        polls    = 0;
        while (!finished && polls < POLL_LIMIT) begin
            read_reg(REG_STATUS, status);
            polls++;
            if (status[STAT_DONE]) begin
                finished = 1'b1;
                // Done and busy are never set together
                if (status[STAT_BUSY]) begin
                    $display("ERR %0t: status 0x%h shows busy together with done", $time, status);
                    error_count++;
                    test_failed = 1'b1;
                end
            end else if (!status[STAT_BUSY]) begin
                $display("ERR %0t: status 0x%h shows neither busy nor done", $time, status);
                error_count++;
                test_failed = 1'b1;
            end
        end
        if (!finished) begin
            $display("Done never came after %0d status polls", POLL_LIMIT);
            error_count++;
            test_failed = 1'b1;
        end
    endtask

    // --------------------
    // Reference model
    // --------------------

    // RISC-V takes its word from the 64-bit product of the extended operands
    function automatic xlen_t reference_result(input logic [1:0] op, input xlen_t a,
                                               input xlen_t b);
        logic [63:0] a_sext;
        logic [63:0] b_sext;
        logic [63:0] a_zext;
        logic [63:0] b_zext;
        logic [63:0] full;
        a_sext = {{32{a[31]}}, a};
        b_sext = {{32{b[31]}}, b};
        a_zext = {32'b0, a};
        b_zext = {32'b0, b};
        case (mul_operation_t'(op))
            MUL, MULH: full = a_sext * b_sext;
            MULHSU:    full = a_sext * b_zext;
            default:   full = a_zext * b_zext;
        endcase
        return (mul_operation_t'(op) == MUL) ? full[31:0] : full[63:32];
    endfunction

    function automatic string op_label(input logic [1:0] op);
        case (op)
            2'd0:    return "MUL";
            2'd1:    return "MULH";
            2'd2:    return "MULHSU";
            default: return "MULHU";
        endcase
    endfunction

    // --------------------
    // Test helpers
    // --------------------
    task automatic finish_test(input string name);
        test_count++;
        if (test_failed) begin
            failed_tests++;
            $display("test %0d %s: failed", test_count, name);
        end else begin
            $display("test %0d %s: ok", test_count, name);
        end
    endtask

    // Runs one full operation and then checks that the result read cleared done
    task automatic run_op(input logic [1:0] op, input xlen_t a, input xlen_t b,
                          input xlen_t expected, input string name);
        xlen_t got;
        xlen_t status;
        test_failed = 1'b0;
        write_reg(REG_OPA, a);
        write_reg(REG_OPB, b);
        write_reg(REG_CTRL, xlen_t'(op));
        wait_for_done();
        read_reg(REG_RESULT, got);
        if (got !== expected) begin
            $display("ERR %0t: %s a=%h b=%h got %h expected %h", $time, name, a, b, got,
                     expected);
            error_count++;
            test_failed = 1'b1;
        end
        read_reg(REG_STATUS, status);
        if (status !== '0) begin
            $display("ERR %0t: %s status 0x%h after result read, expected 0", $time, name,
                     status);
            error_count++;
            test_failed = 1'b1;
        end
        finish_test(name);
    endtask

    // --------------------
    // Sequence
    // --------------------
    initial begin
        xlen_t      rdata;
        int         num_vectors;
        logic [1:0] op;
        xlen_t      a;
        xlen_t      b;
        integer     rnd;

        seed         = 32'h2231_5e3b;
        wb_req       = '0;
        rst_n        = 1'b0;
        test_count   = 0;
        failed_tests = 0;
        error_count  = 0;
        test_failed  = 1'b0;

        // Entries past the file keep an operation word above 3, which ends the list
        for (int i = 0; i < 4 * MAX_VECTORS; i++) begin
            vec_mem[i] = 32'hF000_0000 | i;
        end
        $readmemh("bench/mul_testdata.hex", vec_mem);

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        read_reg(REG_STATUS, rdata);
        if (rdata !== '0) begin
            $display("ERR %0t: status after reset is 0x%h, expected 0", $time, rdata);
            error_count++;
            test_failed = 1'b1;
        end
        read_reg(REG_RESULT, rdata);
        if (rdata !== '0) begin
            $display("ERR %0t: result after reset is 0x%h, expected 0", $time, rdata);
            error_count++;
            test_failed = 1'b1;
        end
        finish_test("reset values");

        // Four words per vector in file order
        num_vectors = 0;
        while (num_vectors < MAX_VECTORS && vec_mem[4*num_vectors] <= 32'd3) begin
            op = vec_mem[4*num_vectors][1:0];
            run_op(op, vec_mem[4*num_vectors+1], vec_mem[4*num_vectors+2],
                   vec_mem[4*num_vectors+3],
                   $sformatf("vector %0d %s", num_vectors, op_label(op)));
            num_vectors++;
        end
        if (num_vectors == 0) begin
            $display("No vectors were read from bench/mul_testdata.hex");
            error_count++;
        end

        for (int i = 0; i < RANDOM_TESTS; i++) begin
            a   = $random(seed);
            b   = $random(seed);
            rnd = $random(seed);
            op  = rnd[1:0];
            run_op(op, a, b, reference_result(op, a, b),
                   $sformatf("random %0d %s", i, op_label(op)));
        end

        // A CTRL write during busy must not replace the running operation
        test_failed = 1'b0;
        write_reg(REG_OPA, 32'd7);
        write_reg(REG_OPB, 32'd6);
        write_reg(REG_CTRL, xlen_t'(MUL));
        write_reg(REG_OPA, 32'h0000_0100);
        write_reg(REG_CTRL, xlen_t'(MULHU));
        wait_for_done();
        read_reg(REG_RESULT, rdata);
        if (rdata !== reference_result(2'd0, 32'd7, 32'd6)) begin
            $display("ERR %0t: result 0x%h after ignored CTRL write, expected 0x%h", $time,
                     rdata, reference_result(2'd0, 32'd7, 32'd6));
            error_count++;
            test_failed = 1'b1;
        end
        read_reg(REG_STATUS, rdata);
        if (rdata !== '0) begin
            $display("ERR %0t: status 0x%h, a dropped CTRL write left work behind", $time,
                     rdata);
            error_count++;
            test_failed = 1'b1;
        end
        finish_test("ctrl write while busy");

        $display("tests run %0d, tests failed %0d, check errors %0d", test_count,
                 failed_tests, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : tb_mul_subsystem

`default_nettype wire

//--- mul_subsystem.f
logic/mul_pkg.sv
logic/wb_pkg.sv
logic/pipelined_array_multiplier.sv
logic/multiplication_unit.sv
logic/mul_wb_slave.sv
logic/mul_subsystem.sv
bench/tb_mul_subsystem.sv

//--- Makefile
# Verilator flow for the bus-attached multiply unit, run from the project root

VERILATOR  ?= verilator
TOP        ?= tb_mul_subsystem
FILELIST   ?= mul_subsystem.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) bench/mul_testdata.hex
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/mul_testdata.hex
// Columns: operation (0 MUL, 1 MULH, 2 MULHSU, 3 MULHU), multiplicand, multiplier, result
// All values in hex, one vector per line
0 00000003 00000007 00000015
0 FFFFFFFF 00000005 FFFFFFFB
0 FFFFFFFE 00000003 FFFFFFFA
0 80000000 80000000 00000000
0 80000000 FFFFFFFF 80000000
0 12345678 00000010 23456780
1 80000000 80000000 40000000
1 FFFFFFFF FFFFFFFF 00000000
1 FFFFFFFF 00000001 FFFFFFFF
1 7FFFFFFF 7FFFFFFF 3FFFFFFF
1 80000000 7FFFFFFF C0000000
1 00000000 FFFFFFFF 00000000
3 FFFFFFFF FFFFFFFF FFFFFFFE
3 80000000 00000002 00000001
3 FFFFFFFF 00000002 00000001
2 FFFFFFFF FFFFFFFF FFFFFFFF
2 80000000 80000000 C0000000
2 FFFFFFFE 80000000 FFFFFFFF
2 7FFFFFFF FFFFFFFF 7FFFFFFE
2 00000002 FFFFFFFF 00000001
